//--- Makefile
# Verilator build for the CSR subsystem testbench.
# Any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/csr_tb.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int CORE_ID     = 1;
    localparam int EXT_REGS    = `CSR_EXT_END - `CSR_EXT_BEGIN;

    localparam int RDY_HIGH   = 0;
    localparam int RDY_HOLD   = 1;
    localparam int RDY_RANDOM = 2;

    localparam csr_pkg::csr_op_e RW = csr_pkg::CSR_OP_RW;
    localparam csr_pkg::csr_op_e RS = csr_pkg::CSR_OP_RS;
    localparam csr_pkg::csr_op_e RC = csr_pkg::CSR_OP_RC;

    typedef struct packed {
        csr_pkg::csr_op_e   op;
        csr_pkg::csr_addr_t addr;
        csr_pkg::warp_id_t  wid;
        logic               use_imm;
        logic [4:0]         imm;
        csr_pkg::word_t     src;
        csr_pkg::lane_id_t  tid;
        logic               stall;
        logic [1:0]         rdy;
    } step_t;

    logic              clk;
    logic              reset;
    csr_pkg::csr_req_t req;
    logic              req_valid;
    logic              req_ready;
    csr_pkg::csr_rsp_t rsp;
    logic              rsp_valid;
    logic              rsp_ready;
    logic              gpu_pending;
    logic [2:0]        commit_count;
    logic              req_pending;

    step_t             steps[$];
    csr_pkg::csr_rsp_t expect_q[$];

    // Reference copies of the architectural state.
    csr_pkg::word_t mscratch_model;
    logic [4:0]     fflags_model;
    logic [2:0]     frm_model;
    csr_pkg::word_t ext_model [`CSR_NUM_WARPS][EXT_REGS];
    csr_pkg::word_t instret_sum;
    int             cycle_count;
    logic           pending_model;
    logic           accepted;

    int          check_count;
    int          error_count;
    int          reply_count;
    int          cycle_limit;
    logic [31:0] lcg_state;

    csr_subsystem #(
        .CORE_ID (CORE_ID)
    ) u_csr_subsystem (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .gpu_pending  (gpu_pending),
        .commit_count (commit_count),
        .req_pending  (req_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_values(string what, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic add_step(csr_pkg::csr_op_e op, int addr, int wid, int use_imm, int imm,
                            logic [31:0] src, int tid, int stall, int rdy);
        step_t s;
        s.op      = op;
        s.addr    = csr_pkg::csr_addr_t'(addr);
        s.wid     = csr_pkg::warp_id_t'(wid);
        s.use_imm = use_imm != 0;
        s.imm     = 5'(imm);
        s.src     = src;
        s.tid     = csr_pkg::lane_id_t'(tid);
        s.stall   = stall != 0;
        s.rdy     = 2'(rdy);
        steps.push_back(s);
    endtask

    // Value a lane should see for an address, taken from the model state.
    function automatic csr_pkg::word_t model_read(csr_pkg::csr_addr_t addr,
                                                  csr_pkg::warp_id_t wid, int lane);
        if (addr >= `CSR_EXT_BEGIN && addr < `CSR_EXT_END) begin
            return ext_model[wid][addr - `CSR_EXT_BEGIN];
        end
        case (addr)
            `CSR_THREAD_ID: return csr_pkg::word_t'(lane);
            `CSR_MHARTID:   return csr_pkg::word_t'(CORE_ID * 16 + 4 * int'(wid) + lane);
            `CSR_FFLAGS:    return csr_pkg::word_t'(fflags_model);
            `CSR_FRM:       return csr_pkg::word_t'(frm_model);
            `CSR_FCSR:      return csr_pkg::word_t'({frm_model, fflags_model});
            `CSR_MSCRATCH:  return mscratch_model;
            `CSR_MCYCLE:    return csr_pkg::word_t'(cycle_count);
            `CSR_MINSTRET:  return instret_sum;
            `CSR_WARP_ID:   return csr_pkg::word_t'(wid);
            `CSR_CORE_ID:   return csr_pkg::word_t'(CORE_ID);
            default:        return '0;
        endcase
    endfunction

    function automatic csr_pkg::csr_rsp_t predict_reply(csr_pkg::csr_req_t r);
        csr_pkg::csr_rsp_t p;
        p.uuid  = r.uuid;
        p.wid   = r.wid;
        p.tmask = r.tmask;
        p.pc    = r.pc;
        p.rd    = r.rd;
        p.wb    = r.wb;
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            p.data[i] = model_read(r.addr, r.wid, i);
        end
        return p;
    endfunction

    task automatic apply_model_write(csr_pkg::csr_req_t r);
        csr_pkg::word_t operand;
        csr_pkg::word_t old_value;
        csr_pkg::word_t new_value;
        operand   = r.use_imm ? csr_pkg::word_t'(r.imm) : r.rs1_data[r.tid];
        old_value = model_read(r.addr, r.wid, 0);
        case (r.op)
            RW:      new_value = operand;
            RS:      new_value = old_value | operand;
            default: new_value = old_value & ~operand;
        endcase
        if (r.op == RW || operand != '0) begin
            if (r.addr >= `CSR_EXT_BEGIN && r.addr < `CSR_EXT_END) begin
                ext_model[r.wid][r.addr - `CSR_EXT_BEGIN] = new_value;
            end else begin
                case (r.addr)
                    `CSR_FFLAGS:   fflags_model = new_value[4:0];
                    `CSR_FRM:      frm_model = new_value[2:0];
                    `CSR_FCSR:     {frm_model, fflags_model} = new_value[7:0];
                    `CSR_MSCRATCH: mscratch_model = new_value;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic compare_reply(csr_pkg::csr_rsp_t got, csr_pkg::csr_rsp_t exp);
        compare_values($sformatf("uuid of reply %0d", reply_count), 32'(got.uuid), 32'(exp.uuid));
        compare_values($sformatf("wid of uuid %0d", exp.uuid), 32'(got.wid), 32'(exp.wid));
        compare_values($sformatf("tmask of uuid %0d", exp.uuid), 32'(got.tmask), 32'(exp.tmask));
        compare_values($sformatf("pc of uuid %0d", exp.uuid), got.pc, exp.pc);
        compare_values($sformatf("rd of uuid %0d", exp.uuid), 32'(got.rd), 32'(exp.rd));
        compare_values($sformatf("wb of uuid %0d", exp.uuid), 32'(got.wb), 32'(exp.wb));
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            compare_values($sformatf("lane %0d data of uuid %0d", i, exp.uuid),
                           got.data[i], exp.data[i]);
        end
    endtask

    // Counters advance on every clock edge out of reset, as in the DUT.
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            instret_sum = instret_sum + csr_pkg::word_t'(commit_count);
            if (cycle_count > cycle_limit) begin
                $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    // Inputs are stable at the falling edge, so handshakes for the next edge are known here.
    always @(negedge clk) begin : monitor
        logic req_fire;
        logic rsp_fire;
        if (!reset) begin
            req_fire = req_valid && req_ready;
            rsp_fire = rsp_valid && rsp_ready;
            compare_values("req_pending", 32'(req_pending), 32'(pending_model));
            compare_values("rsp_valid", 32'(rsp_valid), 32'(expect_q.size() != 0));
            compare_values("req_ready", 32'(req_ready),
                           32'(!gpu_pending && expect_q.size() < 2));
            if (rsp_fire && expect_q.size() != 0) begin
                compare_reply(rsp, expect_q.pop_front());
                reply_count++;
            end
            if (req_fire) begin
                expect_q.push_back(predict_reply(req));
                apply_model_write(req);
            end
            if (rsp_fire) begin
                pending_model = 1'b0;
            end else if (req_fire) begin
                pending_model = 1'b1;
            end
            accepted = req_fire;
        end
    end

    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #DRIVE_DELAY;
        rnd = lcg_next();
        commit_count = rnd[18:16] % 3'd5;
    endtask

    task automatic apply_step(int idx);
        step_t             s;
        csr_pkg::csr_req_t r;
        logic [31:0]       rnd;
        int                waited;
        s = steps[idx];
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            r.rs1_data[i] = lcg_next();
        end
        rnd = lcg_next();
        r.uuid    = 8'(idx);
        r.wid     = s.wid;
        r.tmask   = rnd[19:16];
        r.pc      = 32'h0000_1000 + 32'(idx * 4);
        r.rd      = 5'(idx);
        r.wb      = rnd[24];
        r.op      = s.op;
        r.use_imm = s.use_imm;
        r.imm     = s.imm;
        r.tid     = s.tid;
        r.addr    = s.addr;
        r.rs1_data[s.tid] = s.src;
        rsp_ready = (s.rdy != 2'(RDY_HOLD));
        // A random ready level already applies on the edge that takes the request.
        if (s.rdy == 2'(RDY_RANDOM)) begin
            rnd = lcg_next();
            rsp_ready = rnd[20];
        end
        req = r;
        req_valid = 1'b1;
        if (s.stall) begin
            gpu_pending = 1'b1;
            repeat (3) next_cycle();
            gpu_pending = 1'b0;
        end
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (s.rdy == 2'(RDY_RANDOM)) begin
                rnd = lcg_next();
                rsp_ready = rnd[20];
            end
            // A blocked request under back-pressure means both reply slots are taken.
            if (s.rdy == 2'(RDY_HOLD) && waited == 4 && !accepted) begin
                compare_values("replies held under back-pressure", 32'(expect_q.size()), 32'd2);
                rsp_ready = 1'b1;
            end
        end while (!accepted);
        req_valid = 1'b0;
    endtask

    task automatic build_table();
        for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
            add_step(RW, `CSR_THREAD_ID, w, 1, 5, 0, 0, 0, RDY_HIGH);
            add_step(RS, `CSR_MHARTID, w, 1, 0, 0, 0, 0, RDY_HIGH);
        end
        add_step(RS, `CSR_THREAD_ID, 3, 1, 0, 0, 0, 0, RDY_RANDOM);
        add_step(RW, `CSR_MSCRATCH, 0, 0, 0, 32'hA5A5_0F0F, 2, 0, RDY_HIGH);
        add_step(RS, `CSR_MSCRATCH, 1, 1, 5'h10, 0, 0, 0, RDY_HIGH);
        add_step(RC, `CSR_MSCRATCH, 2, 0, 0, 32'h0000_0F00, 1, 0, RDY_HIGH);
        add_step(RS, `CSR_MSCRATCH, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RC, `CSR_MSCRATCH, 3, 0, 0, 0, 3, 0, RDY_HIGH);
        add_step(RS, `CSR_MSCRATCH, 0, 0, 0, 32'hF000_0000, 0, 1, RDY_RANDOM);
        add_step(RC, `CSR_MSCRATCH, 1, 1, 5'h03, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_MSCRATCH, 2, 1, 5'h1F, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_MSCRATCH, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_FFLAGS, 0, 1, 5'h15, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_FRM, 1, 1, 5'h0E, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_FCSR, 2, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_FCSR, 0, 0, 0, 32'h0000_00A3, 3, 0, RDY_HIGH);
        add_step(RS, `CSR_FFLAGS, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_FRM, 3, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RC, `CSR_FCSR, 0, 1, 5'h01, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_FCSR, 1, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_WARP_ID, 2, 1, 5'h07, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_WARP_ID, 2, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_CORE_ID, 0, 0, 0, 32'h0000_00FF, 1, 0, RDY_HIGH);
        add_step(RS, `CSR_CORE_ID, 3, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_MCYCLE, 0, 0, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_MCYCLE, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_MCYCLE, 0, 1, 0, 0, 0, 1, RDY_HIGH);
        add_step(RW, `CSR_MINSTRET, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_MINSTRET, 1, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RW, 12'h123, 0, 1, 5'h09, 0, 0, 0, RDY_HIGH);
        add_step(RS, 12'h123, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        // Extension window, one copy per warp.
        add_step(RW, `CSR_EXT_BEGIN, 0, 0, 0, 32'h1111_0000, 0, 0, RDY_HIGH);
        add_step(RW, `CSR_EXT_BEGIN, 1, 0, 0, 32'h2222_0000, 1, 0, RDY_HIGH);
        add_step(RS, `CSR_EXT_BEGIN, 0, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_EXT_BEGIN, 2, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_EXT_BEGIN + 7, 3, 1, 5'h0C, 0, 0, 0, RDY_HIGH);
        add_step(RC, `CSR_EXT_BEGIN + 7, 3, 1, 5'h04, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_EXT_BEGIN + 7, 1, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_EXT_BEGIN, 1, 1, 0, 0, 0, 0, RDY_HIGH);
        // Replies held back while requests keep coming.
        add_step(RW, `CSR_EXT_BEGIN + 3, 2, 0, 0, 32'hCAFE_0001, 3, 0, RDY_HOLD);
        add_step(RS, `CSR_EXT_BEGIN + 3, 2, 1, 5'h10, 0, 0, 0, RDY_HOLD);
        add_step(RS, `CSR_MSCRATCH, 1, 0, 0, 32'h0000_0100, 2, 0, RDY_HOLD);
        add_step(RC, `CSR_EXT_BEGIN + 3, 2, 0, 0, 32'h0000_0001, 1, 1, RDY_HOLD);
        add_step(RS, `CSR_EXT_BEGIN + 3, 2, 1, 0, 0, 0, 0, RDY_HIGH);
        add_step(RS, `CSR_MINSTRET, 0, 1, 0, 0, 0, 1, RDY_RANDOM);
        add_step(RS, `CSR_MCYCLE, 3, 1, 0, 0, 0, 0, RDY_HIGH);
    endtask

    initial begin
        lcg_state      = 32'd86;
        reset          = 1'b1;
        req            = '0;
        req_valid      = 1'b0;
        rsp_ready      = 1'b1;
        gpu_pending    = 1'b0;
        commit_count   = '0;
        mscratch_model = '0;
        fflags_model   = '0;
        frm_model      = '0;
        instret_sum    = '0;
        cycle_count    = 0;
        pending_model  = 1'b0;
        accepted       = 1'b0;
        check_count    = 0;
        error_count    = 0;
        reply_count    = 0;
        for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
            for (int r = 0; r < EXT_REGS; r++) begin
                ext_model[w][r] = '0;
            end
        end
        build_table();
        cycle_limit = 20 * steps.size() + 100;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
        end
        rsp_ready = 1'b1;
        while (expect_q.size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
        $display("Summary: %0d steps, %0d replies, %0d checks, %0d errors",
                 steps.size(), reply_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- hw/csr_data.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_data #(
    parameter int CORE_ID = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [2:0]         commit_count,
    input  csr_pkg::csr_addr_t read_addr,
    input  csr_pkg::warp_id_t  read_wid,
    output csr_pkg::word_t     read_data_ro,
    output csr_pkg::word_t     read_data_rw,
    input  logic               write_enable,
    input  csr_pkg::csr_addr_t write_addr,
    input  csr_pkg::word_t     write_data
);

    csr_pkg::word_t mscratch;
    csr_pkg::word_t mcycle;
    csr_pkg::word_t minstret;
    logic [4:0]     fflags;
    logic [2:0]     frm;

    // Writable registers. Writes to any other address are dropped here.
    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= '0;
            fflags   <= '0;
            frm      <= '0;
        end else if (write_enable) begin
            case (write_addr)
                `CSR_FFLAGS: begin
                    fflags <= write_data[4:0];
                end
                `CSR_FRM: begin
                    frm <= write_data[2:0];
                end
                `CSR_FCSR: begin
                    frm    <= write_data[7:5];
                    fflags <= write_data[4:0];
                end
                `CSR_MSCRATCH: begin
                    mscratch <= write_data;
                end
                default: begin
                end
            endcase
        end
    end

    // Free-running cycle count and retired-instruction count.
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle + 1'b1;
            minstret <= minstret + csr_pkg::word_t'(commit_count);
        end
    end

    always_comb begin
        case (read_addr)
            `CSR_FFLAGS: begin
                read_data_rw = csr_pkg::word_t'(fflags);
            end
            `CSR_FRM: begin
                read_data_rw = csr_pkg::word_t'(frm);
            end
            `CSR_FCSR: begin
                read_data_rw = csr_pkg::word_t'({frm, fflags});
            end
            `CSR_MSCRATCH: begin
                read_data_rw = mscratch;
            end
            default: begin
                read_data_rw = '0;
            end
        endcase
    end

    // Thread id and hart id vary per lane and are formed in the unit.
    always_comb begin
        case (read_addr)
            `CSR_MCYCLE: begin
                read_data_ro = mcycle;
            end
            `CSR_MINSTRET: begin
                read_data_ro = minstret;
            end
            `CSR_WARP_ID: begin
                read_data_ro = csr_pkg::word_t'(read_wid);
            end
            `CSR_CORE_ID: begin
                read_data_ro = csr_pkg::word_t'(CORE_ID);
            end
            default: begin
                read_data_ro = '0;
            end
        endcase
    end

endmodule

//--- hw/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Core geometry.
`define CSR_NUM_THREADS 4
`define CSR_NUM_WARPS   4
`define CSR_XLEN        32

// Floating-point status and control.
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

// Machine-level registers.
`define CSR_MSCRATCH    12'h340
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MHARTID     12'hF14

// GPU identity registers.
`define CSR_THREAD_ID   12'hCC0
`define CSR_WARP_ID     12'hCC1
`define CSR_CORE_ID     12'hCC2

// Graphics extension window, half open and aligned to its size.
`define CSR_EXT_BEGIN   12'h7C0
`define CSR_EXT_END     12'h7C8

`endif

//--- hw/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [$clog2(`CSR_NUM_WARPS)-1:0] warp_id_t;
    typedef logic [$clog2(`CSR_NUM_THREADS)-1:0] lane_id_t;
    typedef logic [`CSR_NUM_THREADS-1:0] tmask_t;
    typedef logic [4:0] reg_id_t;
    typedef logic [7:0] uuid_t;
    typedef word_t [`CSR_NUM_THREADS-1:0] lane_words_t;

    typedef enum logic [1:0] {
        CSR_OP_RW = 2'd0,
        CSR_OP_RS = 2'd1,
        CSR_OP_RC = 2'd2
    } csr_op_e;

    typedef struct packed {
        uuid_t       uuid;
        warp_id_t    wid;
        tmask_t      tmask;
        word_t       pc;
        reg_id_t     rd;
        logic        wb;
        csr_op_e     op;
        logic        use_imm;
        logic [4:0]  imm;
        lane_id_t    tid;
        csr_addr_t   addr;
        lane_words_t rs1_data;
    } csr_req_t;

    typedef struct packed {
        uuid_t       uuid;
        warp_id_t    wid;
        tmask_t      tmask;
        word_t       pc;
        reg_id_t     rd;
        logic        wb;
        lane_words_t data;
    } csr_rsp_t;

endpackage

//--- hw/csr_subsystem.sv
`timescale 1ns/1ps

module csr_subsystem #(
    parameter int CORE_ID = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output csr_pkg::csr_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    input  logic              gpu_pending,
    input  logic [2:0]        commit_count,
    output logic              req_pending
);

    csr_pkg::csr_addr_t read_addr;
    csr_pkg::warp_id_t  read_wid;
    csr_pkg::word_t     read_data_ro;
    csr_pkg::word_t     read_data_rw;
    logic               write_enable;
    csr_pkg::csr_addr_t write_addr;
    csr_pkg::word_t     write_data;
    logic               ext_write_enable;
    logic [2:0]         ext_addr;
    csr_pkg::warp_id_t  ext_wid;
    csr_pkg::word_t     ext_write_data;
    csr_pkg::word_t     ext_read_data;

    csr_unit #(
        .CORE_ID (CORE_ID)
    ) u_csr_unit (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .rsp              (rsp),
        .rsp_valid        (rsp_valid),
        .rsp_ready        (rsp_ready),
        .gpu_pending      (gpu_pending),
        .req_pending      (req_pending),
        .read_addr        (read_addr),
        .read_wid         (read_wid),
        .read_data_ro     (read_data_ro),
        .read_data_rw     (read_data_rw),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .ext_write_enable (ext_write_enable),
        .ext_addr         (ext_addr),
        .ext_wid          (ext_wid),
        .ext_write_data   (ext_write_data),
        .ext_read_data    (ext_read_data)
    );

    csr_data #(
        .CORE_ID (CORE_ID)
    ) u_csr_data (
        .clk          (clk),
        .reset        (reset),
        .commit_count (commit_count),
        .read_addr    (read_addr),
        .read_wid     (read_wid),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data)
    );

    ext_csr_bank u_ext_csr_bank (
        .clk          (clk),
        .reset        (reset),
        .write_enable (ext_write_enable),
        .addr         (ext_addr),
        .wid          (ext_wid),
        .write_data   (ext_write_data),
        .read_data    (ext_read_data)
    );

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output csr_pkg::csr_rsp_t  rsp,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    input  logic               gpu_pending,
    output logic               req_pending,
    output csr_pkg::csr_addr_t read_addr,
    output csr_pkg::warp_id_t  read_wid,
    input  csr_pkg::word_t     read_data_ro,
    input  csr_pkg::word_t     read_data_rw,
    output logic               write_enable,
    output csr_pkg::csr_addr_t write_addr,
    output csr_pkg::word_t     write_data,
    output logic               ext_write_enable,
    output logic [2:0]         ext_addr,
    output csr_pkg::warp_id_t  ext_wid,
    output csr_pkg::word_t     ext_write_data,
    input  csr_pkg::word_t     ext_read_data
);

    localparam int LANE_BITS = $clog2(`CSR_NUM_THREADS);
    localparam int WARP_BITS = $clog2(`CSR_NUM_WARPS);

    csr_pkg::word_t       operand;
    csr_pkg::word_t       old_value;
    csr_pkg::word_t       new_value;
    csr_pkg::word_t       shared_data;
    csr_pkg::lane_words_t lane_data;
    csr_pkg::csr_rsp_t    rsp_in;
    logic                 ext_hit;
    logic                 write_cond;
    logic                 sbuf_ready;
    logic                 req_fire;
    logic                 rsp_fire;

    assign ext_hit   = (req.addr >= `CSR_EXT_BEGIN) && (req.addr < `CSR_EXT_END);
    assign req_ready = sbuf_ready && !gpu_pending;
    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;

    assign operand = req.use_imm ? csr_pkg::word_t'(req.imm) : req.rs1_data[req.tid];
    assign old_value = ext_hit ? ext_read_data : read_data_rw;

    always_comb begin
        case (req.op)
            csr_pkg::CSR_OP_RW: new_value = operand;
            csr_pkg::CSR_OP_RS: new_value = old_value | operand;
            default:            new_value = old_value & ~operand;
        endcase
    end

    // Set and clear with a zero operand are plain reads.
    assign write_cond = (req.op == csr_pkg::CSR_OP_RW) || (operand != '0);

    assign read_addr    = req.addr;
    assign read_wid     = req.wid;
    assign write_enable = req_fire && write_cond && !ext_hit;
    assign write_addr   = req.addr;
    assign write_data   = new_value;

    // The window is aligned, so the low address bits select the register.
    assign ext_write_enable = req_fire && write_cond && ext_hit;
    assign ext_addr         = req.addr[2:0];
    assign ext_wid          = req.wid;
    assign ext_write_data   = new_value;

    assign shared_data = ext_hit ? ext_read_data : (read_data_ro | read_data_rw);

    always_comb begin
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            case (req.addr)
                `CSR_THREAD_ID: begin
                    lane_data[i] = csr_pkg::word_t'(i);
                end
                `CSR_MHARTID: begin
                    lane_data[i] = csr_pkg::word_t'((CORE_ID << (WARP_BITS + LANE_BITS))
                                 + (int'(req.wid) << LANE_BITS) + i);
                end
                default: begin
                    lane_data[i] = shared_data;
                end
            endcase
        end
    end

    always_comb begin
        rsp_in.uuid  = req.uuid;
        rsp_in.wid   = req.wid;
        rsp_in.tmask = req.tmask;
        rsp_in.pc    = req.pc;
        rsp_in.rd    = req.rd;
        rsp_in.wb    = req.wb;
        rsp_in.data  = lane_data;
    end

    skid_buffer #(
        .DATAW ($bits(csr_pkg::csr_rsp_t))
    ) u_rsp_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid && !gpu_pending),
        .ready_in  (sbuf_ready),
        .data_in   (rsp_in),
        .data_out  (rsp),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready)
    );

    // A reply handshake on the accepting edge wins over the new request.
    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else begin
            if (req_fire) begin
                req_pending <= 1'b1;
            end
            if (rsp_fire) begin
                req_pending <= 1'b0;
            end
        end
    end

endmodule

//--- hw/ext_csr_bank.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module ext_csr_bank (
    input  logic              clk,
    input  logic              reset,
    input  logic              write_enable,
    input  logic [2:0]        addr,
    input  csr_pkg::warp_id_t wid,
    input  csr_pkg::word_t    write_data,
    output csr_pkg::word_t    read_data
);

    localparam int NUM_REGS = `CSR_EXT_END - `CSR_EXT_BEGIN;

    // One copy of the window per warp.
    csr_pkg::word_t regs [`CSR_NUM_WARPS][NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (write_enable) begin
            regs[wid][addr] <= write_data;
        end
    end

    assign read_data = regs[wid][addr];

endmodule

//--- hw/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out,
    output logic             valid_out,
    input  logic             ready_out
);

    logic             out_valid;
    logic [DATAW-1:0] out_data;
    logic             use_buffer;
    logic [DATAW-1:0] buffer;
    logic             push;
    logic             out_load;

    // The overflow entry is the only thing that can block the input.
    assign ready_in = ~use_buffer;
    assign push     = valid_in && ready_in;
    assign out_load = ~out_valid || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            use_buffer <= 1'b0;
        end else if (out_load) begin
            out_valid  <= use_buffer || push;
            use_buffer <= 1'b0;
        end else if (push) begin
            use_buffer <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= use_buffer ? buffer : data_in;
        end
        if (push && !out_load) begin
            buffer <= data_in;
        end
    end

    assign valid_out = out_valid;
    assign data_out  = out_data;

endmodule

//--- project.f
+incdir+hw
hw/csr_pkg.sv
hw/skid_buffer.sv
hw/csr_data.sv
hw/ext_csr_bank.sv
hw/csr_unit.sv
hw/csr_subsystem.sv
dv/csr_tb.sv
